/* cpu_control.sv */
`timescale 1ns/1ps

module cpu_control #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = 64'h8000_0000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              instr,
    input  logic                     instr_valid,
    input  logic                     instr_error,
    input  logic                     data_rd_valid,
    input  logic                     data_rd_error,
    input  logic                     branch_taken,
    input  logic [cpu_pkg::xlen-1:0] next_pc,
    input  logic                     last_step,
    output cpu_pkg::instr_u          ir,
    output logic [cpu_pkg::xlen-1:0] pc_rd,
    output logic                     reg_wen,
    output logic                     wb_sel_mul,
    output logic                     mul_start,
    output logic                     mem_rd,
    output logic                     mem_wr,
    output logic                     out_valid,
    output logic [cpu_pkg::xlen-1:0] pc_done,
    output logic                     done,
    output logic                     error
);

    cpu_pkg::ctrl_state_e state;

    logic [6:0] opcode;
    logic       is_alu;
    logic       is_mul;
    logic       is_ld;
    logic       is_sd;
    logic       is_beq;
    logic       is_ecall;
    logic       bad_target;
    logic       mem_ack;
    logic       retire;

    assign opcode = ir.r_fmt.opcode;

    // Decode of the supported subset
    assign is_alu = (opcode == cpu_pkg::op_imm && ir.i_fmt.funct3 == cpu_pkg::f3_add) ||
                    (opcode == cpu_pkg::op_reg && ir.r_fmt.funct3 == cpu_pkg::f3_add &&
                     (ir.r_fmt.funct7 == cpu_pkg::f7_add ||
                      ir.r_fmt.funct7 == cpu_pkg::f7_sub));
    assign is_mul = opcode == cpu_pkg::op_reg && ir.r_fmt.funct3 == cpu_pkg::f3_mul &&
                    ir.r_fmt.funct7 == cpu_pkg::f7_mul;
    assign is_ld  = opcode == cpu_pkg::op_load && ir.i_fmt.funct3 == cpu_pkg::f3_ld;
    assign is_sd  = opcode == cpu_pkg::op_store && ir.s_fmt.funct3 == cpu_pkg::f3_sd;
    assign is_beq = opcode == cpu_pkg::op_branch && ir.b_fmt.funct3 == cpu_pkg::f3_beq;
    assign is_ecall = opcode == cpu_pkg::op_system && ir.i_fmt.imm == 12'd0 &&
                      ir.i_fmt.rs1 == 5'd0 && ir.i_fmt.funct3 == 3'd0 &&
                      ir.i_fmt.rd == 5'd0;

    // Taken branch to a non word-aligned target
    assign bad_target = branch_taken && next_pc[1:0] != 2'b00;

    assign mem_ack = data_rd_valid && !data_rd_error;

    assign retire = (state == cpu_pkg::s_exec && (is_alu || (is_beq && !bad_target))) ||
                    (state == cpu_pkg::s_mem && mem_ack) ||
                    (state == cpu_pkg::s_mul && last_step);

    assign reg_wen = (state == cpu_pkg::s_exec && is_alu) ||
                     (state == cpu_pkg::s_mem && mem_rd && mem_ack) ||
                     (state == cpu_pkg::s_mul && last_step);
    assign wb_sel_mul = (state == cpu_pkg::s_mul);
    assign mul_start  = (state == cpu_pkg::s_exec && is_mul);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= cpu_pkg::s_fetch;
            pc_rd     <= reset_pc;
            mem_rd    <= 1'b0;
            mem_wr    <= 1'b0;
            out_valid <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            out_valid <= retire;
            if (retire) begin
                pc_rd <= next_pc;
            end
            case (state)
                cpu_pkg::s_fetch: begin
                    if (instr_error) begin
                        state <= cpu_pkg::s_err;
                        error <= 1'b1;
                    end else if (instr_valid) begin
                        state <= cpu_pkg::s_exec;
                    end
                end
                cpu_pkg::s_exec: begin
                    if (is_alu || (is_beq && !bad_target)) begin
                        state <= cpu_pkg::s_fetch;
                    end else if (is_ld || is_sd) begin
                        mem_rd <= is_ld;
                        mem_wr <= is_sd;
                        state  <= cpu_pkg::s_mem;
                    end else if (is_mul) begin
                        state <= cpu_pkg::s_mul;
                    end else if (is_ecall) begin
                        state <= cpu_pkg::s_halt;
                        done  <= 1'b1;
                    end else begin
                        state <= cpu_pkg::s_err;
                        error <= 1'b1;
                    end
                end
                cpu_pkg::s_mem: begin
                    if (data_rd_error) begin
                        mem_rd <= 1'b0;
                        mem_wr <= 1'b0;
                        state  <= cpu_pkg::s_err;
                        error  <= 1'b1;
                    end else if (data_rd_valid) begin
                        mem_rd <= 1'b0;
                        mem_wr <= 1'b0;
                        state  <= cpu_pkg::s_fetch;
                    end
                end
                cpu_pkg::s_mul: begin
                    if (last_step) begin
                        state <= cpu_pkg::s_fetch;
                    end
                end
                default: begin
                    // Halt and error are sticky
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::s_fetch && instr_valid) begin
            ir <= instr;
        end
    end

    // ECALL also reports its pc
    always_ff @(posedge clk) begin
        if (retire || (state == cpu_pkg::s_exec && is_ecall)) begin
            pc_done <= pc_rd;
        end
    end

    a_one_request: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd && mem_wr));

    // Once halted, the core stays halted and retires nothing
    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst)
        (state == cpu_pkg::s_halt) |=> (state == cpu_pkg::s_halt && !out_valid));

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc  = 64'h8000_0000,
    parameter int                       mul_steps = cpu_pkg::mul_steps
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              instr,
    input  logic                     instr_valid,
    input  logic                     instr_error,
    input  logic [cpu_pkg::xlen-1:0] data_rd,
    input  logic                     data_rd_valid,
    input  logic                     data_rd_error,
    output logic [cpu_pkg::xlen-1:0] pc_rd,
    output logic                     mem_rd,
    output logic                     mem_wr,
    output logic [2:0]               mem_op,
    output logic [cpu_pkg::xlen-1:0] addr,
    output logic [cpu_pkg::xlen-1:0] data_wr,
    output logic                     out_valid,
    output logic [cpu_pkg::xlen-1:0] pc_done,
    output logic                     done,
    output logic                     error
);

    cpu_pkg::instr_u          ir;
    logic [cpu_pkg::xlen-1:0] rs1_data;
    logic [cpu_pkg::xlen-1:0] rs2_data;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic [cpu_pkg::xlen-1:0] next_pc;
    logic [cpu_pkg::xlen-1:0] product;
    logic [cpu_pkg::xlen-1:0] wb_data;
    logic                     branch_taken;
    logic                     reg_wen;
    logic                     wb_sel_mul;
    logic                     mul_start;
    logic                     step_en;
    logic                     last_step;

    assign mem_op  = cpu_pkg::mem_op_dw;
    assign data_wr = rs2_data;
    // mem_rd is still high on the edge that returns load data
    assign wb_data = wb_sel_mul ? product : (mem_rd ? data_rd : alu_result);

    cpu_control #(.reset_pc(reset_pc)) u_control (
        .clk(clk), .rst(rst),
        .instr(instr), .instr_valid(instr_valid), .instr_error(instr_error),
        .data_rd_valid(data_rd_valid), .data_rd_error(data_rd_error),
        .branch_taken(branch_taken), .next_pc(next_pc), .last_step(last_step),
        .ir(ir), .pc_rd(pc_rd), .reg_wen(reg_wen), .wb_sel_mul(wb_sel_mul),
        .mul_start(mul_start), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .out_valid(out_valid), .pc_done(pc_done), .done(done), .error(error)
    );

    cpu_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1(ir.r_fmt.rs1), .rs2(ir.r_fmt.rs2), .rd(ir.r_fmt.rd),
        .wen(reg_wen), .wdata(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    cpu_exec u_exec (
        .ir(ir), .pc(pc_rd), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_result(alu_result), .mem_addr(addr),
        .branch_taken(branch_taken), .next_pc(next_pc)
    );

    cpu_step_counter #(.mul_steps(mul_steps)) u_step_counter (
        .clk(clk), .rst(rst), .mul_start(mul_start),
        .step_en(step_en), .last_step(last_step)
    );

    cpu_mul u_mul (
        .clk(clk), .rst(rst), .mul_start(mul_start), .step_en(step_en),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .product(product)
    );

endmodule

/* cpu_exec.sv */
`timescale 1ns/1ps

module cpu_exec (
    input  cpu_pkg::instr_u          ir,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] rs1_data,
    input  logic [cpu_pkg::xlen-1:0] rs2_data,
    output logic [cpu_pkg::xlen-1:0] alu_result,
    output logic [cpu_pkg::xlen-1:0] mem_addr,
    output logic                     branch_taken,
    output logic [cpu_pkg::xlen-1:0] next_pc
);

    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_s;
    logic [cpu_pkg::xlen-1:0] imm_b;

    // Sign-extended immediates
    assign imm_i = {{(cpu_pkg::xlen-12){ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
    assign imm_s = {{(cpu_pkg::xlen-12){ir.s_fmt.imm_hi[6]}},
                    ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
    assign imm_b = {{(cpu_pkg::xlen-12){ir.b_fmt.imm12}},
                    ir.b_fmt.imm11, ir.b_fmt.imm10_5, ir.b_fmt.imm4_1, 1'b0};

    always_comb begin
        alu_result   = rs1_data + imm_i;
        mem_addr     = rs1_data + imm_i;
        branch_taken = 1'b0;
        case (ir.r_fmt.opcode)
            cpu_pkg::op_reg: begin
                if (ir.r_fmt.funct7 == cpu_pkg::f7_sub) begin
                    alu_result = rs1_data - rs2_data;
                end else begin
                    alu_result = rs1_data + rs2_data;
                end
            end
            cpu_pkg::op_store: begin
                mem_addr = rs1_data + imm_s;
            end
            cpu_pkg::op_branch: begin
                branch_taken = (ir.b_fmt.funct3 == cpu_pkg::f3_beq) &&
                               (rs1_data == rs2_data);
            end
            default: begin
                // ADDI and LD use the defaults
            end
        endcase
    end

    assign next_pc = branch_taken ? pc + imm_b : pc + 64'd4;

endmodule

/* cpu_mul.sv */
`timescale 1ns/1ps

module cpu_mul (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mul_start,
    input  logic                     step_en,
    input  logic [cpu_pkg::xlen-1:0] rs1_data,
    input  logic [cpu_pkg::xlen-1:0] rs2_data,
    output logic [cpu_pkg::xlen-1:0] product
);

    logic [cpu_pkg::xlen-1:0] mcand;
    logic [cpu_pkg::xlen-1:0] mplier;
    logic [cpu_pkg::xlen-1:0] acc;

    // Accumulator after the current step, so the last step writes back directly
    assign product = acc + (mplier[0] ? mcand : '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            acc    <= '0;
            mplier <= '0;
        end else if (mul_start) begin
            acc    <= '0;
            mplier <= rs2_data;
        end else if (step_en) begin
            acc    <= product;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand <= rs1_data;
        end else if (step_en) begin
            mcand <= mcand << 1;
        end
    end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen = 64;
    localparam int mul_steps = 64;

    // Major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_mul = 3'b000;
    localparam logic [2:0] f3_ld  = 3'b011;
    localparam logic [2:0] f3_sd  = 3'b011;
    localparam logic [2:0] f3_beq = 3'b000;

    localparam logic [6:0] f7_add = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;
    localparam logic [6:0] f7_mul = 7'b0000001;

    // Doubleword access on the data port
    localparam logic [2:0] mem_op_dw = 3'b011;

    typedef enum logic [2:0] {
        s_fetch,
        s_exec,
        s_mem,
        s_mul,
        s_halt,
        s_err
    } ctrl_state_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // One fetched word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_u;

endpackage

/* cpu_regfile.sv */
`timescale 1ns/1ps

module cpu_regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     wen,
    input  logic [cpu_pkg::xlen-1:0] wdata,
    output logic [cpu_pkg::xlen-1:0] rs1_data,
    output logic [cpu_pkg::xlen-1:0] rs2_data
);

    logic [cpu_pkg::xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero regardless of array contents
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* cpu_step_counter.sv */
`timescale 1ns/1ps

module cpu_step_counter #(
    parameter int mul_steps = cpu_pkg::mul_steps
) (
    input  logic clk,
    input  logic rst,
    input  logic mul_start,
    output logic step_en,
    output logic last_step
);

    localparam int cnt_w = $clog2(mul_steps + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (mul_start) begin
            count <= cnt_w'(mul_steps);
        end else if (step_en) begin
            count <= count - 1'b1;
        end
    end

    assign step_en   = (count != '0);
    assign last_step = (count == cnt_w'(1));

    // Final step lands exactly mul_steps cycles after start
    a_last_step: assert property (@(posedge clk) disable iff (!rst)
        mul_start |-> ##mul_steps (last_step && step_en));

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_cpu -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
exit 1

/* tb.f */
cpu_pkg.sv
cpu_regfile.sv
cpu_exec.sv
cpu_mul.sv
cpu_step_counter.sv
cpu_control.sv
cpu_core.sv
tb_cpu.sv

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam logic [63:0] reset_pc   = 64'h0000_0000_0000_1000;
    localparam logic [31:0] ecall_word = 32'h0000_0073;
    // 28 instructions over all runs, one MUL, seven resets
    localparam int n_instr     = 28;
    localparam int n_mul       = 1;
    localparam int n_resets    = 7;
    localparam int cycle_limit = 40 * n_instr + 64 * n_mul + 20 * n_resets;

    logic        clk = 1'b0;
    logic        rst = 1'b0;
    logic [31:0] instr = 32'd0;
    logic        instr_valid = 1'b0;
    logic        instr_error = 1'b0;
    logic [63:0] data_rd = 64'd0;
    logic        data_rd_valid = 1'b0;
    logic        data_rd_error = 1'b0;
    logic [63:0] pc_rd;
    logic        mem_rd;
    logic        mem_wr;
    logic [2:0]  mem_op;
    logic [63:0] addr;
    logic [63:0] data_wr;
    logic        out_valid;
    logic [63:0] pc_done;
    logic        done;
    logic        error;

    logic [31:0] imem [0:63];
    logic [63:0] dmem [0:255];
    logic [63:0] fetched [$];
    logic [63:0] retired [$];
    logic [63:0] store_addr [$];
    logic [63:0] store_data [$];
    logic        ierr_mode = 1'b0;
    logic        fetch_pend = 1'b0;
    logic        mem_busy = 1'b0;
    int          fetch_wait = 0;
    int          mem_wait = 0;
    int          seed = 82;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    cpu_core #(.reset_pc(reset_pc), .mul_steps(64)) DUT (
        .clk(clk), .rst(rst),
        .instr(instr), .instr_valid(instr_valid), .instr_error(instr_error),
        .data_rd(data_rd), .data_rd_valid(data_rd_valid), .data_rd_error(data_rd_error),
        .pc_rd(pc_rd), .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_op(mem_op),
        .addr(addr), .data_wr(data_wr), .out_valid(out_valid), .pc_done(pc_done),
        .done(done), .error(error)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] rtype_word(input int f7, input int rs2, input int rs1,
                                               input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] ld_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] imem_word(input logic [63:0] pc);
        logic [63:0] off;
        off = pc - reset_pc;
        if (off < 64'd256) begin
            return imem[off[7:2]];
        end
        return 32'd0;
    endfunction

    // Instruction and data memory models
    always @(negedge clk) begin
        if (!rst) begin
            instr_valid   <= 1'b0;
            instr_error   <= 1'b0;
            data_rd_valid <= 1'b0;
            fetch_pend = 1'b1;
            fetch_wait = 0;
            mem_busy   = 1'b0;
        end else begin
            instr_valid   <= 1'b0;
            instr_error   <= 1'b0;
            data_rd_valid <= 1'b0;
            // A retire leaves the core waiting for its next word
            if (out_valid) begin
                fetch_pend = 1'b1;
                fetch_wait = $random(seed) & 3;
            end
            if (fetch_pend) begin
                if (fetch_wait == 0) begin
                    fetch_pend = 1'b0;
                    fetched.push_back(pc_rd);
                    instr <= imem_word(pc_rd);
                    if (ierr_mode) begin
                        instr_error <= 1'b1;
                    end else begin
                        instr_valid <= 1'b1;
                    end
                end else begin
                    fetch_wait--;
                end
            end
            if ((mem_rd || mem_wr) && !mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $random(seed) & 3;
                // Every access is a doubleword
                check_value("mem_op", 64'(mem_op), 64'h3);
            end
            if (mem_busy) begin
                if (mem_wait == 0) begin
                    mem_busy = 1'b0;
                    data_rd_valid <= 1'b1;
                    if (mem_wr) begin
                        store_addr.push_back(addr);
                        store_data.push_back(data_wr);
                    end else begin
                        data_rd <= dmem[addr[10:3]];
                    end
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst && out_valid) begin
            retired.push_back(pc_done);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_store(input int idx, input logic [63:0] a, input logic [63:0] d);
        if (idx < store_addr.size()) begin
            check_value("addr", store_addr[idx], a);
            check_value("data_wr", store_data[idx], d);
        end else begin
            errors++;
            $display("No store seen where one to address %h was expected", a);
        end
    endtask

    task automatic check_retire(input int idx, input logic [63:0] pc);
        if (idx < retired.size()) begin
            check_value("pc_done", retired[idx], pc);
        end else begin
            errors++;
            $display("Instruction at pc %h never retired", pc);
        end
    endtask

    task automatic check_fetch(input int idx, input logic [63:0] pc);
        if (idx < fetched.size()) begin
            check_value("pc_rd", fetched[idx], pc);
        end else begin
            errors++;
            $display("No fetch seen where one from pc %h was expected", pc);
        end
    endtask

    task automatic clear_imem();
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'd0;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst <= 1'b0;
        repeat (16) @(negedge clk);
        rst <= 1'b1;
    endtask

    task automatic wait_for_halt();
        while (!done && !error) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset();
        apply_reset();
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("mem_rd", 64'(mem_rd), 64'd0);
        check_value("mem_wr", 64'(mem_wr), 64'd0);
        check_value("done", 64'(done), 64'd0);
        check_value("error", 64'(error), 64'd0);
        check_value("pc_rd", pc_rd, reset_pc);
    endtask

    task automatic test_arith();
        logic [63:0] r1;
        logic [63:0] r2;
        logic [63:0] r3;
        logic [63:0] r4;
        int rb;
        int sb;
        r1 = 64'd1000;
        r2 = 64'd0 - 64'd7;
        r3 = r1 + r2;
        r4 = r2 - r1;
        clear_imem();
        imem[0] = addi_word(1, 0, 1000);
        imem[1] = addi_word(2, 0, -7);
        imem[2] = rtype_word(0, 2, 1, 3);
        imem[3] = rtype_word(32, 1, 2, 4);
        imem[4] = addi_word(5, 0, 256);
        imem[5] = sd_word(4, 5, 8);
        imem[6] = rtype_word(0, 3, 4, 6);
        imem[7] = sd_word(6, 5, 16);
        imem[8] = ecall_word;
        apply_reset();
        rb = retired.size();
        sb = store_addr.size();
        wait_for_halt();
        check_value("error", 64'(error), 64'd0);
        check_value("retire count", 64'(retired.size() - rb), 64'd8);
        for (int k = 0; k < 8; k++) begin
            check_retire(rb + k, reset_pc + 64'(4 * k));
        end
        check_store(sb, 64'd264, r4);
        check_store(sb + 1, 64'd272, r4 + r3);
    endtask

    task automatic test_ld_sd();
        int sb;
        clear_imem();
        imem[0] = addi_word(1, 0, 64);
        imem[1] = ld_word(2, 1, 16);
        imem[2] = sd_word(2, 1, -8);
        imem[3] = ecall_word;
        apply_reset();
        sb = store_addr.size();
        wait_for_halt();
        check_value("error", 64'(error), 64'd0);
        check_store(sb, 64'h38, dmem[10]);
    endtask

    task automatic test_beq();
        logic [63:0] pc_b1;
        logic [63:0] pc_b2;
        logic [63:0] pc_sd;
        int fb;
        int rb;
        int sb;
        // Operands are 5 and 5 for the first branch, 5 and 0 for the second
        pc_b1 = reset_pc + 64'd8;
        pc_b2 = (5 == 5) ? pc_b1 + 64'd12 : pc_b1 + 64'd4;
        pc_sd = (5 == 0) ? pc_b2 - 64'd16 : pc_b2 + 64'd4;
        clear_imem();
        imem[0] = addi_word(1, 0, 5);
        imem[1] = addi_word(2, 0, 5);
        imem[2] = beq_word(1, 2, 12);
        imem[3] = addi_word(3, 0, 1);
        imem[4] = addi_word(3, 0, 2);
        imem[5] = beq_word(1, 0, -16);
        imem[6] = sd_word(3, 0, 128);
        imem[7] = ecall_word;
        apply_reset();
        fb = fetched.size();
        rb = retired.size();
        sb = store_addr.size();
        wait_for_halt();
        check_value("error", 64'(error), 64'd0);
        check_fetch(fb, reset_pc);
        check_fetch(fb + 1, reset_pc + 64'd4);
        check_fetch(fb + 2, pc_b1);
        check_fetch(fb + 3, pc_b2);
        check_fetch(fb + 4, pc_sd);
        check_fetch(fb + 5, pc_sd + 64'd4);
        check_retire(rb + 2, pc_b1);
        check_retire(rb + 3, pc_b2);
        check_retire(rb + 4, pc_sd);
        // Skipped instructions leave x3 at zero
        check_store(sb, 64'd128, 64'd0);
    endtask

    task automatic test_mul();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] prod;
        int sb;
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        prod = a * b;
        dmem[64] = a;
        dmem[65] = b;
        clear_imem();
        imem[0] = addi_word(1, 0, 512);
        imem[1] = ld_word(2, 1, 0);
        imem[2] = ld_word(3, 1, 8);
        imem[3] = rtype_word(1, 3, 2, 4);
        imem[4] = sd_word(4, 1, 16);
        imem[5] = ecall_word;
        apply_reset();
        sb = store_addr.size();
        wait_for_halt();
        check_value("error", 64'(error), 64'd0);
        check_store(sb, 64'd528, prod);
    endtask

    task automatic test_halt();
        int fb;
        int rb;
        clear_imem();
        imem[0] = addi_word(1, 0, 3);
        imem[1] = ecall_word;
        apply_reset();
        wait_for_halt();
        check_value("done", 64'(done), 64'd1);
        check_value("error", 64'(error), 64'd0);
        check_value("pc_done", pc_done, reset_pc + 64'd4);
        fb = fetched.size();
        rb = retired.size();
        repeat (10) @(negedge clk);
        check_value("fetch count", 64'(fetched.size() - fb), 64'd0);
        check_value("retire count", 64'(retired.size() - rb), 64'd0);
        // Fetch address stays on the ECALL
        check_value("pc_rd", pc_rd, reset_pc + 64'd4);
        check_value("done", 64'(done), 64'd1);
    endtask

    task automatic test_instr_error();
        int rb;
        clear_imem();
        imem[0] = addi_word(1, 0, 3);
        ierr_mode = 1'b1;
        apply_reset();
        rb = retired.size();
        wait_for_halt();
        check_value("error", 64'(error), 64'd1);
        check_value("done", 64'(done), 64'd0);
        check_value("retire count", 64'(retired.size() - rb), 64'd0);
        ierr_mode = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 64'h0123_4567_89ab_cdef ^ ((64'(i) << 3) * 64'h9e37_79b9_7f4a_7c15);
        end
        clear_imem();
        test_reset();
        test_arith();
        test_ld_sd();
        test_beq();
        test_mul();
        test_halt();
        test_instr_error();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
